// File: rtl/uart_bridge_defs.svh
`ifndef UART_BRIDGE_DEFS_SVH
`define UART_BRIDGE_DEFS_SVH

// ************************************************************
// bit timing
// ************************************************************

// clock cycles per bit
`define UB_BAUD_DIV 434

// idle bit-times between head and data byte of a write
`define UB_GAP_BITS 10

// bit-times to wait for a response start bit
`define UB_RESP_BITS 40

// ************************************************************
// APB register map, byte offsets
// ************************************************************

`define UB_REG_CMD    4'h0
`define UB_REG_STATUS 4'h4
`define UB_REG_RDATA  4'h8

`endif

// File: rtl/uart_bridge_pkg.sv
package uart_bridge_pkg;

  // ************************************************************
  // host command word, bit 15 selects write
  // ************************************************************
  typedef struct packed {
    logic       write;
    logic [6:0] addr;
    logic [7:0] data;  // ignored for reads
  } ub_cmd_t;

  // ************************************************************
  // STATUS register, bits 3:0
  // ************************************************************
  typedef struct packed {
    logic busy;
    logic rd_valid;
    logic parity_err;
    logic frame_err;
  } ub_status_t;

  // ************************************************************
  // one received response frame
  // ************************************************************
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } ub_rx_result_t;

endpackage

// File: rtl/apb_cmd_regs.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module apb_cmd_regs
  import uart_bridge_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [3:0]    paddr,
  input  logic [31:0]   pwdata,
  output logic [31:0]   prdata,
  output logic          pready,
  output logic          pslverr,
  output logic          cmd_start,
  output ub_cmd_t       cmd,
  input  logic          busy,
  input  logic          rx_done,
  input  ub_rx_result_t rx_result
);

  ub_status_t status;
  logic       access;
  logic       cmd_accept;
  logic       rdata_read;
  logic       rd_valid;
  logic       parity_err;
  logic       frame_err;
  logic [7:0] rdata;

  assign access = psel & penable;
  assign pready = 1'b1;  // zero wait states

  // cmd_start covers the cycle before busy rises
  assign cmd_accept = access & pwrite & (paddr == `UB_REG_CMD) & ~busy & ~cmd_start;
  assign rdata_read = access & ~pwrite & (paddr == `UB_REG_RDATA);

  assign status = '{busy: busy, rd_valid: rd_valid, parity_err: parity_err,
                    frame_err: frame_err};

  always_comb
  begin
    pslverr = 1'b0;
    if (access)
    begin
      case (paddr)
        `UB_REG_CMD:    pslverr = pwrite & (busy | cmd_start);  // refused while busy
        `UB_REG_STATUS: pslverr = pwrite;                       // read only
        `UB_REG_RDATA:  pslverr = pwrite;
        default:        pslverr = 1'b1;
      endcase
    end
  end

  always_comb
  begin
    case (paddr)
      `UB_REG_CMD:    prdata = {16'h0, cmd};
      `UB_REG_STATUS: prdata = {28'h0, status};
      `UB_REG_RDATA:  prdata = {24'h0, rdata};
      default:        prdata = 32'h0;
    endcase
  end

  // ************************************************************
  // control and sticky status bits
  // ************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_start  <= 1'b0;
      rd_valid   <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end
    else
    begin
      cmd_start <= cmd_accept;
      if (cmd_accept)
      begin
        rd_valid   <= 1'b0;
        parity_err <= 1'b0;
        frame_err  <= 1'b0;
      end
      if (rdata_read)
        rd_valid <= 1'b0;
      if (rx_done)
      begin
        rd_valid   <= 1'b1;  // set wins over a same-cycle read
        parity_err <= rx_result.parity_err;
        frame_err  <= rx_result.frame_err;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_accept)
      cmd <= ub_cmd_t'(pwdata[15:0]);
    if (rx_done)
      rdata <= rx_result.data;
  end

endmodule

// File: rtl/cmd_sequencer.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module cmd_sequencer
  import uart_bridge_pkg::*;
#(
  parameter int BAUD_DIV = `UB_BAUD_DIV
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          cmd_start,
  input  ub_cmd_t       cmd,
  output logic          busy,
  output logic          tx_start,
  output logic [7:0]    tx_byte,
  input  logic          tx_busy,
  output logic          rx_arm,
  input  logic          rx_done,
  input  ub_rx_result_t rx_result_in,
  output ub_rx_result_t rx_result
);

  localparam int GAP_CYC = `UB_GAP_BITS * BAUD_DIV;
  localparam int GW      = $clog2(GAP_CYC);

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEAD,
    GAP,
    SEND_DATA,
    WAIT_RESP
  } state_t;

  state_t        state;
  logic          tx_busy_q;
  logic          tx_done;
  logic [GW-1:0] gap_cnt;

  // end of a frame is the falling edge of tx_busy
  assign tx_done = tx_busy_q & ~tx_busy;

  // response goes straight on to the register block
  assign rx_result = rx_result_in;

  // ************************************************************
  // frame ordering
  // ************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      busy      <= 1'b0;
      tx_start  <= 1'b0;
      tx_byte   <= 8'h0;
      rx_arm    <= 1'b0;
      tx_busy_q <= 1'b0;
      gap_cnt   <= '0;
    end
    else
    begin
      tx_busy_q <= tx_busy;
      tx_start  <= 1'b0;
      rx_arm    <= 1'b0;
      case (state)
        IDLE:
        begin
          if (cmd_start)
          begin
            busy     <= 1'b1;
            tx_start <= 1'b1;
            tx_byte  <= {cmd.write, cmd.addr};  // head byte
            state    <= SEND_HEAD;
          end
        end
        SEND_HEAD:
        begin
          if (tx_done)
          begin
            if (cmd.write)
            begin
              gap_cnt <= '0;
              state   <= GAP;
            end
            else
            begin
              rx_arm <= 1'b1;
              state  <= WAIT_RESP;
            end
          end
        end
        GAP:
        begin
          // three cycles of pipeline between tx_busy falling and the next start bit
          if (gap_cnt == GW'(GAP_CYC - 3))
          begin
            tx_start <= 1'b1;
            tx_byte  <= cmd.data;
            state    <= SEND_DATA;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        SEND_DATA:
        begin
          if (tx_done)
          begin
            busy  <= 1'b0;
            state <= IDLE;
          end
        end
        WAIT_RESP:
        begin
          if (rx_done)
          begin
            busy  <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: rtl/uart_tx_frame.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module uart_tx_frame #(
  parameter int BAUD_DIV = `UB_BAUD_DIV
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  localparam int CW = $clog2(BAUD_DIV);

  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_cnt;
  logic [9:0]    shift;  // data, parity, stop

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;  // line idles high
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= 4'd0;
      shift    <= 10'h3ff;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx       <= 1'b0;  // start bit
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= 4'd0;
        shift    <= {1'b1, ~^tx_byte, tx_byte};  // odd parity
      end
    end
    else if (baud_cnt == CW'(BAUD_DIV - 1))
    begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd10)
        tx_busy <= 1'b0;  // stop bit done, tx stays high
      else
      begin
        tx      <= shift[0];  // LSB first
        shift   <= {1'b1, shift[9:1]};
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

endmodule

// File: rtl/uart_rx_frame.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module uart_rx_frame
  import uart_bridge_pkg::*;
#(
  parameter int BAUD_DIV = `UB_BAUD_DIV
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rx_arm,
  input  logic          rx,
  output logic          rx_done,
  output ub_rx_result_t rx_result
);

  localparam int CW       = $clog2(BAUD_DIV);
  localparam int RESP_CYC = `UB_RESP_BITS * BAUD_DIV;
  localparam int TW       = $clog2(RESP_CYC);

  typedef enum logic [1:0] {
    R_IDLE,
    R_WAIT,
    R_START,
    R_DATA
  } rx_state_t;

  rx_state_t     state;
  logic [2:0]    rx_sync;
  logic          rx_s;
  logic          rx_fall;
  logic [CW-1:0] baud_cnt;
  logic [TW-1:0] to_cnt;
  logic [3:0]    bit_cnt;
  logic [9:0]    shift;
  logic [9:0]    shift_nxt;

  assign rx_s      = rx_sync[1];  // after two flops
  assign rx_fall   = rx_sync[2] & ~rx_s;
  assign shift_nxt = {rx_s, shift[9:1]};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= R_IDLE;
      rx_sync   <= 3'b111;
      rx_done   <= 1'b0;
      rx_result <= '0;
      baud_cnt  <= '0;
      to_cnt    <= '0;
      bit_cnt   <= 4'd0;
      shift     <= '0;
    end
    else
    begin
      rx_sync <= {rx_sync[1:0], rx};
      rx_done <= 1'b0;
      case (state)
        R_IDLE:
        begin
          if (rx_arm)
          begin
            to_cnt <= '0;
            state  <= R_WAIT;
          end
        end
        R_WAIT:
        begin
          if (rx_fall)
          begin
            baud_cnt <= '0;
            state    <= R_START;
          end
          else if (to_cnt == TW'(RESP_CYC - 1))
          begin
            rx_done   <= 1'b1;  // timeout, no start bit
            rx_result <= '{data: 8'h0, parity_err: 1'b0, frame_err: 1'b1};
            state     <= R_IDLE;
          end
          else
            to_cnt <= to_cnt + 1'b1;
        end
        R_START:
        begin
          if (baud_cnt == CW'(BAUD_DIV / 2 - 1))
          begin
            baud_cnt <= '0;
            bit_cnt  <= 4'd0;
            state    <= rx_s ? R_WAIT : R_DATA;  // glitch goes back to waiting
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        R_DATA:
        begin
          if (baud_cnt == CW'(BAUD_DIV - 1))
          begin
            baud_cnt <= '0;
            shift    <= shift_nxt;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9)  // stop bit sampled
            begin
              rx_done   <= 1'b1;
              rx_result <= '{data: shift_nxt[7:0],
                             parity_err: shift_nxt[8] != ~^shift_nxt[7:0],
                             frame_err: ~shift_nxt[9]};
              state     <= R_IDLE;
            end
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/uart_bridge_top.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module uart_bridge_top
  import uart_bridge_pkg::*;
#(
  parameter int BAUD_DIV = `UB_BAUD_DIV
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        tx,
  input  logic        rx
);

  ub_cmd_t       cmd;
  ub_rx_result_t rx_result_raw;
  ub_rx_result_t rx_result;
  logic          cmd_start;
  logic          busy;
  logic          tx_start;
  logic [7:0]    tx_byte;
  logic          tx_busy;
  logic          rx_arm;
  logic          rx_done;

  // ************************************************************
  // host side, sequencer, serial side
  // ************************************************************
  apb_cmd_regs u_regs (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .cmd_start, .cmd, .busy, .rx_done, .rx_result
  );

  cmd_sequencer #(.BAUD_DIV(BAUD_DIV)) u_seq (
    .clk, .rst_n, .cmd_start, .cmd, .busy,
    .tx_start, .tx_byte, .tx_busy,
    .rx_arm, .rx_done, .rx_result_in(rx_result_raw), .rx_result
  );

  uart_tx_frame #(.BAUD_DIV(BAUD_DIV)) u_tx (
    .clk, .rst_n, .tx_start, .tx_byte, .tx_busy, .tx
  );

  uart_rx_frame #(.BAUD_DIV(BAUD_DIV)) u_rx (
    .clk, .rst_n, .rx_arm, .rx, .rx_done, .rx_result(rx_result_raw)
  );

endmodule

// File: test/tb_uart_bridge.sv
`timescale 1ns/1ps
`include "uart_bridge_defs.svh"

module tb_uart_bridge
  import uart_bridge_pkg::*;
;

  localparam int BAUD_DIV    = 16;
  localparam int MODE_BADPAR = 1;
  localparam int MODE_SILENT = 2;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        tx;
  logic        rx;

  logic [31:0] lcg_state;
  logic [7:0]  mem [128];  // remote device memory
  ub_cmd_t     seen [$];   // commands rebuilt from tx
  int          resp_mode;
  int          resp_delay;
  int          errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;

  uart_bridge_top #(.BAUD_DIV(BAUD_DIV)) DUT (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .tx, .rx
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // ************************************************************
  // compare tasks
  // ************************************************************
  task automatic check_cmd(input ub_cmd_t got, input ub_cmd_t exp);
    if (got !== exp)
    begin
      $display("ERR cmd: got 0x%h expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input ub_status_t got, input ub_status_t exp);
    if (got !== exp)
    begin
      $display("ERR status: got 0x%h expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("ERR rdata: got 0x%h expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // ************************************************************
  // APB host
  // ************************************************************
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    #2;  // sample ahead of the rising edge
    while (!pready && waited < 20)
    begin
      @(negedge clk);
      #2;
      waited++;
    end
    if (!pready)
    begin
      $display("APB transfer to 0x%h never saw pready", addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic wait_idle();
    logic [31:0] rd;
    int          polls;
    polls = 0;
    apb_read(`UB_REG_STATUS, rd);
    while (rd[3] && polls < 2000)  // busy bit
    begin
      apb_read(`UB_REG_STATUS, rd);
      polls++;
    end
    if (rd[3])
    begin
      $display("timeout waiting for busy to clear");
      errors++;
    end
  endtask

  // ************************************************************
  // remote device
  // ************************************************************
  task automatic receive_frame(output logic [7:0] data);
    logic [9:0] bits;
    int         i;
    @(negedge clk);
    while (tx !== 1'b0)
      @(negedge clk);
    repeat (BAUD_DIV / 2 - 1) @(negedge clk);  // middle of start bit
    for (i = 0; i < 10; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      bits[i] = tx;
    end
    data = bits[7:0];
    if (bits[8] !== ~^bits[7:0])
    begin
      $display("frame 0x%h received with bad parity", data);
      errors++;
    end
    if (bits[9] !== 1'b1)
    begin
      $display("frame 0x%h received without a stop bit", data);
      errors++;
    end
  endtask

  task automatic send_response(input logic [7:0] data);
    logic [10:0] frame;
    int          i;
    if (resp_mode != MODE_SILENT)
    begin
      frame = {1'b1, (~^data) ^ (resp_mode == MODE_BADPAR), data, 1'b0};
      repeat (resp_delay * BAUD_DIV) @(negedge clk);
      for (i = 0; i < 11; i++)
      begin
        rx = frame[i];
        repeat (BAUD_DIV) @(negedge clk);
      end
    end
  endtask

  initial
  begin
    logic [7:0] b;
    ub_cmd_t    c;
    @(posedge rst_n);
    forever
    begin
      receive_frame(b);
      c = '{write: b[7], addr: b[6:0], data: 8'h0};
      if (c.write)
      begin
        receive_frame(b);
        c.data      = b;
        mem[c.addr] = b;
        seen.push_back(c);
      end
      else
      begin
        seen.push_back(c);
        send_response(mem[c.addr]);
      end
    end
  end

  // ************************************************************
  // test sequences
  // ************************************************************
  task automatic expect_cmd_frame(input ub_cmd_t exp);
    if (seen.size() == 0)
    begin
      $display("remote device saw no command, expected 0x%h", exp);
      errors++;
    end
    else
      check_cmd(seen.pop_front(), exp);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != err_mark)
    begin
      tests_failed++;
      $display("%-32s FAIL", name);
    end
    else
      $display("%-32s ok", name);
    err_mark = errors;
  endtask

  task automatic run_write(input logic [6:0] addr, input logic [7:0] data);
    logic        err;
    logic [31:0] rd;
    ub_cmd_t     exp;
    exp = '{write: 1'b1, addr: addr, data: data};
    apb_write(`UB_REG_CMD, {16'h0, exp}, err);
    check_bit("pslverr", err, 1'b0);
    wait_idle();
    expect_cmd_frame(exp);
    apb_read(`UB_REG_STATUS, rd);
    check_status(ub_status_t'(rd[3:0]), '0);
    finish_test($sformatf("write 0x%h <- 0x%h", addr, data));
  endtask

  task automatic run_read(input logic [6:0] addr, input int mode, input logic [7:0] junk);
    logic        err;
    logic [31:0] rd;
    ub_cmd_t     exp;
    ub_status_t  exp_st;
    logic [7:0]  exp_data;
    resp_mode  = mode;
    resp_delay = 1 + (lcg_next() >> 16) % 10;
    exp        = '{write: 1'b0, addr: addr, data: 8'h0};
    exp_data   = (mode == MODE_SILENT) ? 8'h00 : mem[addr];
    exp_st     = '{busy: 1'b0, rd_valid: 1'b1, parity_err: mode == MODE_BADPAR,
                   frame_err: mode == MODE_SILENT};
    apb_write(`UB_REG_CMD, {16'h0, 1'b0, addr, junk}, err);  // data field is don't care
    check_bit("pslverr", err, 1'b0);
    wait_idle();
    expect_cmd_frame(exp);
    apb_read(`UB_REG_STATUS, rd);
    check_status(ub_status_t'(rd[3:0]), exp_st);
    apb_read(`UB_REG_RDATA, rd);
    check_rdata(rd[7:0], exp_data);
    exp_st.rd_valid = 1'b0;
    apb_read(`UB_REG_STATUS, rd);
    check_status(ub_status_t'(rd[3:0]), exp_st);
    finish_test($sformatf("read 0x%h mode %0d", addr, mode));
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] rd;
    logic        err;
    ub_cmd_t     first;
    int          i;
    lcg_state    = 32'd89;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    resp_mode    = MODE_SILENT;
    resp_delay   = 1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 4'h0;
    pwdata       = 32'h0;
    rx           = 1'b1;
    rst_n        = 1'b0;
    for (i = 0; i < 128; i++)
      mem[i] = {i[6:0], 1'b1} ^ 8'h3c;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_bit("tx", tx, 1'b1);
    apb_read(`UB_REG_STATUS, rd);
    check_status(ub_status_t'(rd[3:0]), '0);
    finish_test("reset state");

    for (i = 0; i < 6; i++)
    begin
      r = lcg_next();
      run_write(r[22:16], r[30:23]);
    end

    // first three reads cover each response mode once
    for (i = 0; i < 12; i++)
    begin
      r = lcg_next();
      run_read(r[22:16], (i < 3) ? i : (r[31:24] % 3), r[15:8]);
    end

    r     = lcg_next();
    first = '{write: 1'b1, addr: r[22:16], data: r[30:23]};
    apb_write(`UB_REG_CMD, {16'h0, first}, err);
    check_bit("pslverr", err, 1'b0);
    apb_write(`UB_REG_CMD, {16'h0, ~first}, err);  // lands while busy
    check_bit("pslverr", err, 1'b1);
    wait_idle();
    expect_cmd_frame(first);
    repeat (20 * BAUD_DIV) @(negedge clk);
    if (seen.size() != 0)
    begin
      $display("remote device saw %0d commands after the refused one", seen.size());
      errors++;
    end
    apb_read(`UB_REG_STATUS, rd);
    check_status(ub_status_t'(rd[3:0]), '0);
    finish_test("command refused while busy");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+rtl
rtl/uart_bridge_pkg.sv
rtl/apb_cmd_regs.sv
rtl/cmd_sequencer.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_bridge_top.sv
test/tb_uart_bridge.sv

// File: Bender.yml
package:
  name: uart_bridge

export_include_dirs:
  - rtl

sources:
  - rtl/uart_bridge_pkg.sv
  - rtl/apb_cmd_regs.sv
  - rtl/cmd_sequencer.sv
  - rtl/uart_tx_frame.sv
  - rtl/uart_rx_frame.sv
  - rtl/uart_bridge_top.sv
  - target: test
    files:
      - test/tb_uart_bridge.sv
